// File: verilog/proc_pkg.sv
`default_nettype none

package proc_pkg;

   typedef logic [15:0] word_t;      // Data, address or instruction word
   typedef logic [2:0]  reg_addr_t;
   typedef logic [4:0]  opcode_t;    // Instruction bits 15 to 11
   typedef logic [1:0]  alu_op_t;

   // Opcodes in the supported subset
   localparam opcode_t OP_HALT  = 5'b00000;
   localparam opcode_t OP_NOP   = 5'b00001;
   localparam opcode_t OP_J     = 5'b00100;
   localparam opcode_t OP_ADDI  = 5'b01000;
   localparam opcode_t OP_BEQZ  = 5'b01100;
   localparam opcode_t OP_BNEZ  = 5'b01101;
   localparam opcode_t OP_ST    = 5'b10000;
   localparam opcode_t OP_LD    = 5'b10001;
   localparam opcode_t OP_LBI   = 5'b11000;
   localparam opcode_t OP_RTYPE = 5'b11011;

   // R-format extension bits map straight onto these
   localparam alu_op_t ALU_ADD = 2'b00;
   localparam alu_op_t ALU_SUB = 2'b01;   // rs minus rt
   localparam alu_op_t ALU_XOR = 2'b10;
   localparam alu_op_t ALU_AND = 2'b11;

   localparam word_t NOP_INSTR = {OP_NOP, 11'b0};
   localparam word_t RESET_PC  = 16'h0000;
   localparam word_t PC_STEP   = 16'd2;   // Byte addressed

endpackage

`default_nettype wire

// File: verilog/pipe_if.sv
`timescale 1ns/10ps
`default_nettype none

// Fetch/decode register
interface fd_if;
   logic            valid;
   proc_pkg::word_t instr;
   proc_pkg::word_t pc_next;   // PC of this instruction plus 2

   modport src (output valid, instr, pc_next);
   modport dst (input valid, instr, pc_next);
   modport mon (input valid, instr, pc_next);
endinterface

// Decode/execute register
interface de_if;
   logic                valid;
   proc_pkg::opcode_t   op;
   proc_pkg::alu_op_t   alu_op;
   proc_pkg::word_t     src_a;
   proc_pkg::word_t     src_b;
   proc_pkg::word_t     store_data;
   proc_pkg::word_t     imm;          // Already sign extended
   proc_pkg::word_t     pc_next;
   proc_pkg::reg_addr_t dest;
   logic                reg_write;
   logic                mem_read;
   logic                mem_write;
   logic                branch_z;
   logic                branch_nz;
   logic                jump;
   logic                halt;

   modport src (output valid, op, alu_op, src_a, src_b, store_data, imm, pc_next,
                dest, reg_write, mem_read, mem_write, branch_z, branch_nz, jump, halt);
   modport dst (input valid, op, alu_op, src_a, src_b, store_data, imm, pc_next,
                dest, reg_write, mem_read, mem_write, branch_z, branch_nz, jump, halt);
   modport mon (input valid, op, alu_op, src_a, src_b, store_data, imm, pc_next,
                dest, reg_write, mem_read, mem_write, branch_z, branch_nz, jump, halt);
endinterface

// Execute/memory register
interface em_if;
   logic                valid;
   proc_pkg::word_t     result;       // ALU result or memory address
   proc_pkg::word_t     store_data;
   proc_pkg::reg_addr_t dest;
   logic                reg_write;
   logic                mem_read;
   logic                mem_write;
   logic                halt;

   modport src (output valid, result, store_data, dest, reg_write, mem_read, mem_write, halt);
   modport dst (input valid, result, store_data, dest, reg_write, mem_read, mem_write, halt);
   modport mon (input valid, result, store_data, dest, reg_write, mem_read, mem_write, halt);
endinterface

`default_nettype wire

// File: verilog/fetch.sv
`timescale 1ns/10ps
`default_nettype none

module fetch (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  stall,
   input  wire                  flush,
   input  wire                  halt_seen,
   input  wire proc_pkg::word_t target,
   input  wire proc_pkg::word_t instruction_f,
   output proc_pkg::word_t      PC,
   fd_if.src                    fd
);

   proc_pkg::word_t pc_plus;

   assign pc_plus = PC + proc_pkg::PC_STEP;

   always_ff @(posedge clk) begin
      if (rst) begin
         PC       <= proc_pkg::RESET_PC;
         fd.valid <= 1'b0;
         fd.instr <= proc_pkg::NOP_INSTR;
      end else if (flush) begin
         PC       <= target;                  // Redirect beats stall
         fd.valid <= 1'b0;
         fd.instr <= proc_pkg::NOP_INSTR;
      end else if (!stall) begin
         if (halt_seen) begin
            fd.valid <= 1'b0;                 // PC frozen, feed bubbles
            fd.instr <= proc_pkg::NOP_INSTR;
         end else begin
            PC       <= pc_plus;
            fd.valid <= 1'b1;
            fd.instr <= instruction_f;
         end
      end
   end

   // Return address only moves with a real fetch
   always_ff @(posedge clk) begin
      if (!stall && !flush && !halt_seen)
         fd.pc_next <= pc_plus;
   end

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
   input  wire                      clk,
   input  wire                      rst,
   input  wire proc_pkg::reg_addr_t rd_addr_a,
   input  wire proc_pkg::reg_addr_t rd_addr_b,
   output proc_pkg::word_t          rd_data_a,
   output proc_pkg::word_t          rd_data_b,
   input  wire                      wb_en,
   input  wire proc_pkg::reg_addr_t wb_addr,
   input  wire proc_pkg::word_t     wb_data
);

   proc_pkg::word_t regs [8];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (wb_en) begin
         regs[wb_addr] <= wb_data;
      end
   end

   // Writeback value shows up in the same cycle
   assign rd_data_a = (wb_en && wb_addr == rd_addr_a) ? wb_data : regs[rd_addr_a];
   assign rd_data_b = (wb_en && wb_addr == rd_addr_b) ? wb_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: verilog/decode.sv
`timescale 1ns/10ps
`default_nettype none

module decode (
   input  wire                      clk,
   input  wire                      rst,
   fd_if.dst                        fd,
   de_if.src                        de,
   input  wire                      stall,
   input  wire                      flush,
   input  wire                      wb_en,
   input  wire proc_pkg::reg_addr_t wb_addr,
   input  wire proc_pkg::word_t     wb_data,
   output proc_pkg::reg_addr_t      rs,
   output proc_pkg::reg_addr_t      rt,
   output logic                     use_rs,
   output logic                     use_rt,
   output logic                     halt_seen,
   output logic                     err
);

   proc_pkg::opcode_t   op;
   proc_pkg::word_t     rd_data_a;
   proc_pkg::word_t     rd_data_b;
   proc_pkg::word_t     imm;
   proc_pkg::reg_addr_t dest;
   proc_pkg::alu_op_t   alu_op;
   logic reg_write, mem_read, mem_write;
   logic branch_z, branch_nz, jump, halt, illegal;
   logic live;      // Valid and not squashed
   logic halt_q;

   assign op   = fd.instr[15:11];
   assign rs   = fd.instr[10:8];
   assign rt   = fd.instr[7:5];
   assign live = fd.valid & ~flush;

   regfile regfile_inst (
      .clk       (clk),
      .rst       (rst),
      .rd_addr_a (rs),
      .rd_addr_b (rt),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wb_en     (wb_en),
      .wb_addr   (wb_addr),
      .wb_data   (wb_data)
   );

   always_comb begin
      dest      = fd.instr[7:5];
      imm       = {{11{fd.instr[4]}}, fd.instr[4:0]};   // imm5 by default
      alu_op    = proc_pkg::ALU_ADD;
      use_rs    = 1'b0;
      use_rt    = 1'b0;
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      branch_z  = 1'b0;
      branch_nz = 1'b0;
      jump      = 1'b0;
      halt      = 1'b0;
      illegal   = 1'b0;
      case (op)
         proc_pkg::OP_HALT: halt = 1'b1;
         proc_pkg::OP_NOP: ;
         proc_pkg::OP_J: begin
            jump = 1'b1;
            imm  = {{5{fd.instr[10]}}, fd.instr[10:0]};
         end
         proc_pkg::OP_ADDI: begin
            use_rs    = 1'b1;
            reg_write = 1'b1;
         end
         proc_pkg::OP_BEQZ, proc_pkg::OP_BNEZ: begin
            use_rs    = 1'b1;
            branch_z  = (op == proc_pkg::OP_BEQZ);
            branch_nz = (op == proc_pkg::OP_BNEZ);
            imm       = {{8{fd.instr[7]}}, fd.instr[7:0]};
         end
         proc_pkg::OP_ST: begin
            use_rs    = 1'b1;
            use_rt    = 1'b1;     // Store data
            mem_write = 1'b1;
         end
         proc_pkg::OP_LD: begin
            use_rs    = 1'b1;
            reg_write = 1'b1;
            mem_read  = 1'b1;
         end
         proc_pkg::OP_LBI: begin
            reg_write = 1'b1;
            dest      = fd.instr[10:8];
            imm       = {{8{fd.instr[7]}}, fd.instr[7:0]};
         end
         proc_pkg::OP_RTYPE: begin
            use_rs    = 1'b1;
            use_rt    = 1'b1;
            reg_write = 1'b1;
            dest      = fd.instr[4:2];
            alu_op    = fd.instr[1:0];
         end
         default: illegal = 1'b1;   // Runs on as a NOP
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         err    <= 1'b0;
         halt_q <= 1'b0;
      end else begin
         if (live && illegal)
            err <= 1'b1;
         if (live && halt)
            halt_q <= 1'b1;
      end
   end

   // Freeze fetch from the HALT's own decode cycle on
   assign halt_seen = halt_q | (live & halt);

   always_ff @(posedge clk) begin
      if (rst || stall || !live) begin
         de.valid     <= 1'b0;              // Bubble
         de.reg_write <= 1'b0;
         de.mem_read  <= 1'b0;
         de.mem_write <= 1'b0;
         de.branch_z  <= 1'b0;
         de.branch_nz <= 1'b0;
         de.jump      <= 1'b0;
         de.halt      <= 1'b0;
      end else begin
         de.valid     <= 1'b1;
         de.reg_write <= reg_write;
         de.mem_read  <= mem_read;
         de.mem_write <= mem_write;
         de.branch_z  <= branch_z;
         de.branch_nz <= branch_nz;
         de.jump      <= jump;
         de.halt      <= halt;
      end
   end

   always_ff @(posedge clk) begin
      de.op         <= op;
      de.alu_op     <= alu_op;
      de.src_a      <= rd_data_a;
      de.src_b      <= rd_data_b;
      de.store_data <= rd_data_b;
      de.imm        <= imm;
      de.pc_next    <= fd.pc_next;
      de.dest       <= dest;
   end

endmodule

`default_nettype wire

// File: verilog/hdu.sv
`timescale 1ns/10ps
`default_nettype none

module hdu (
   input  wire proc_pkg::reg_addr_t rs,
   input  wire proc_pkg::reg_addr_t rt,
   input  wire                      use_rs,
   input  wire                      use_rt,
   input  wire                      valid_d,
   de_if.mon                        de,
   em_if.mon                        em,
   output logic                     stall
);

   logic ex_wr;
   logic mem_wr;
   logic rs_hit;
   logic rt_hit;

   // Producers still ahead of the register file
   assign ex_wr  = de.valid & de.reg_write;
   assign mem_wr = em.valid & em.reg_write;

   assign rs_hit = use_rs & ((ex_wr & (de.dest == rs)) | (mem_wr & (em.dest == rs)));
   assign rt_hit = use_rt & ((ex_wr & (de.dest == rt)) | (mem_wr & (em.dest == rt)));

   // Writeback needs no stall, the register file passes it through
   assign stall = valid_d & (rs_hit | rt_hit);

endmodule

`default_nettype wire

// File: verilog/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute (
   input  wire             clk,
   input  wire             rst,
   de_if.dst               de,
   em_if.src               em,
   output logic            flush,
   output proc_pkg::word_t target
);

   proc_pkg::word_t operand_b;
   proc_pkg::word_t alu_out;
   proc_pkg::word_t result;
   logic            taken;

   // Only R-format reads rt as an operand
   assign operand_b = (de.op == proc_pkg::OP_RTYPE) ? de.src_b : de.imm;

   always_comb begin
      case (de.alu_op)
         proc_pkg::ALU_ADD: alu_out = de.src_a + operand_b;
         proc_pkg::ALU_SUB: alu_out = de.src_a - operand_b;
         proc_pkg::ALU_XOR: alu_out = de.src_a ^ operand_b;
         default:           alu_out = de.src_a & operand_b;
      endcase
   end

   assign result = (de.op == proc_pkg::OP_LBI) ? de.imm : alu_out;

   assign taken = de.jump
                | (de.branch_z  & (de.src_a == '0))
                | (de.branch_nz & (de.src_a != '0));

   assign flush  = de.valid & taken;          // Squashes the two younger slots
   assign target = de.pc_next + de.imm;

   always_ff @(posedge clk) begin
      if (rst) begin
         em.valid     <= 1'b0;
         em.reg_write <= 1'b0;
         em.mem_read  <= 1'b0;
         em.mem_write <= 1'b0;
         em.halt      <= 1'b0;
      end else begin
         em.valid     <= de.valid;
         em.reg_write <= de.reg_write;
         em.mem_read  <= de.mem_read;
         em.mem_write <= de.mem_write;
         em.halt      <= de.halt;
      end
   end

   always_ff @(posedge clk) begin
      em.result     <= result;
      em.store_data <= de.store_data;
      em.dest       <= de.dest;
   end

endmodule

`default_nettype wire

// File: verilog/memory_wb.sv
`timescale 1ns/10ps
`default_nettype none

module memory_wb (
   input  wire                      clk,
   input  wire                      rst,
   em_if.dst                        em,
   output proc_pkg::word_t          mem_addr,
   output proc_pkg::word_t          mem_wdata,
   output logic                     mem_write,
   output logic                     mem_read,
   input  wire proc_pkg::word_t     mem_rdata,
   output logic                     wb_en,
   output proc_pkg::reg_addr_t      wb_addr,
   output proc_pkg::word_t          wb_data,
   output logic                     halted
);

   assign mem_addr  = em.result;
   assign mem_wdata = em.store_data;
   assign mem_write = em.valid & em.mem_write;   // One strobe per ST
   assign mem_read  = em.valid & em.mem_read;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_en  <= 1'b0;
         halted <= 1'b0;
      end else begin
         wb_en <= em.valid & em.reg_write;
         if (em.valid && em.halt)
            halted <= 1'b1;                       // Sticky until reset
      end
   end

   // Memory is combinational, so load data is ready this cycle
   always_ff @(posedge clk) begin
      wb_addr <= em.dest;
      wb_data <= em.mem_read ? mem_rdata : em.result;
   end

endmodule

`default_nettype wire

// File: verilog/proc.sv
`timescale 1ns/10ps
`default_nettype none

module proc (
   input  wire                  clk,
   input  wire                  rst,
   output wire proc_pkg::word_t PC,
   input  wire proc_pkg::word_t instruction_f,
   output wire proc_pkg::word_t mem_addr,
   output wire proc_pkg::word_t mem_wdata,
   output wire                  mem_write,
   output wire                  mem_read,
   input  wire proc_pkg::word_t mem_rdata,
   output wire                  err,
   output wire                  halted
);

   logic                stall;
   logic                flush;
   logic                halt_seen;
   proc_pkg::word_t     target;
   logic                wb_en;
   proc_pkg::reg_addr_t wb_addr;
   proc_pkg::word_t     wb_data;
   proc_pkg::reg_addr_t rs;
   proc_pkg::reg_addr_t rt;
   logic                use_rs;
   logic                use_rt;

   fd_if fd_bus ();
   de_if de_bus ();
   em_if em_bus ();

   fetch fetch_inst (
      .clk           (clk),
      .rst           (rst),
      .stall         (stall),
      .flush         (flush),
      .halt_seen     (halt_seen),
      .target        (target),
      .instruction_f (instruction_f),
      .PC            (PC),
      .fd            (fd_bus.src)
   );

   decode decode_inst (
      .clk       (clk),
      .rst       (rst),
      .fd        (fd_bus.dst),
      .de        (de_bus.src),
      .stall     (stall),
      .flush     (flush),
      .wb_en     (wb_en),
      .wb_addr   (wb_addr),
      .wb_data   (wb_data),
      .rs        (rs),
      .rt        (rt),
      .use_rs    (use_rs),
      .use_rt    (use_rt),
      .halt_seen (halt_seen),
      .err       (err)
   );

   hdu hdu_inst (
      .rs      (rs),
      .rt      (rt),
      .use_rs  (use_rs),
      .use_rt  (use_rt),
      .valid_d (fd_bus.valid),
      .de      (de_bus.mon),
      .em      (em_bus.mon),
      .stall   (stall)
   );

   execute execute_inst (
      .clk    (clk),
      .rst    (rst),
      .de     (de_bus.dst),
      .em     (em_bus.src),
      .flush  (flush),
      .target (target)
   );

   memory_wb memory_wb_inst (
      .clk       (clk),
      .rst       (rst),
      .em        (em_bus.dst),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_write (mem_write),
      .mem_read  (mem_read),
      .mem_rdata (mem_rdata),
      .wb_en     (wb_en),
      .wb_addr   (wb_addr),
      .wb_data   (wb_data),
      .halted    (halted)
   );

endmodule

`default_nettype wire

// File: tests/proc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module proc_tb;

   localparam int CLK_PERIOD      = 100;
   localparam int CYCLES_PER_CASE = 200;
   localparam int RESET_CYCLES    = 5;

   logic            clk;
   logic            rst;
   proc_pkg::word_t PC;
   proc_pkg::word_t instruction_f;
   proc_pkg::word_t mem_addr;
   proc_pkg::word_t mem_wdata;
   proc_pkg::word_t mem_rdata;
   logic            mem_write;
   logic            mem_read;
   logic            err;
   logic            halted;

   proc_pkg::word_t imem [256];     // Word indexed, address bits 8 to 1
   proc_pkg::word_t dmem [256];
   proc_pkg::word_t cases [1024];   // Flat image of the cases file
   int              pos;
   int              n_cases;

   // Both memories answer in the same cycle
   assign instruction_f = imem[PC[8:1]];
   assign mem_rdata     = mem_read ? dmem[mem_addr[8:1]] : 16'h0000;   // Data only on a read

   proc proc_inst (
      .clk           (clk),
      .rst           (rst),
      .PC            (PC),
      .instruction_f (instruction_f),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .mem_write     (mem_write),
      .mem_read      (mem_read),
      .mem_rdata     (mem_rdata),
      .err           (err),
      .halted        (halted)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input proc_pkg::word_t got,
                             input proc_pkg::word_t exp);
      if (got !== exp)
         fail_now($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_now($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp));
   endtask

   task automatic read_word(output proc_pkg::word_t w);
      w = cases[pos];
      pos++;
   endtask

   // NOP everywhere, data tagged with its own word index
   task automatic fill_memories();
      for (int i = 0; i < 256; i++) begin
         imem[8'(i)] = proc_pkg::NOP_INSTR;
         dmem[8'(i)] = {8'(i), ~8'(i)};
      end
   endtask

   task automatic run_case(input int idx);
      proc_pkg::word_t w;
      proc_pkg::word_t a;
      proc_pkg::word_t exp_err;
      proc_pkg::word_t exp_addr [$];
      proc_pkg::word_t exp_data [$];
      int              n_prog;
      int              n_data;
      int              n_stores;

      @(posedge clk);
      rst <= 1'b1;
      @(posedge clk);
      fill_memories();
      read_word(w);
      n_prog = int'(w);
      for (int i = 0; i < n_prog; i++) begin
         read_word(w);
         imem[8'(i)] = w;
      end
      read_word(w);
      n_data = int'(w);
      for (int i = 0; i < n_data; i++) begin
         read_word(a);
         read_word(w);
         dmem[a[8:1]] = w;
      end
      read_word(w);
      n_stores = int'(w);
      for (int i = 0; i < n_stores; i++) begin
         read_word(a);
         read_word(w);
         exp_addr.push_back(a);
         exp_data.push_back(w);
      end
      read_word(exp_err);
      repeat (RESET_CYCLES - 1) @(posedge clk);
      rst <= 1'b0;

      // Reset state, before the first fetch
      @(negedge clk);
      check_word("PC", PC, 16'h0000);
      check_bit("mem_write", mem_write, 1'b0);
      check_bit("mem_read", mem_read, 1'b0);
      check_bit("err", err, 1'b0);
      check_bit("halted", halted, 1'b0);

      while (!halted) begin
         @(negedge clk);
         if (mem_write) begin
            if (exp_addr.size() == 0)
               fail_now($sformatf("Case %0d made a store that the program does not have", idx));
            check_word("mem_addr", mem_addr, exp_addr.pop_front());
            check_word("mem_wdata", mem_wdata, exp_data.pop_front());
            dmem[mem_addr[8:1]] = mem_wdata;
         end
      end

      if (exp_addr.size() != 0)
         fail_now($sformatf("Case %0d halted with %0d stores still missing",
                            idx, exp_addr.size()));
      check_bit("err", err, exp_err[0]);

      repeat (3) begin
         @(negedge clk);
         if (mem_write || mem_read)
            fail_now($sformatf("Case %0d accessed data memory at %h after HALT",
                               idx, mem_addr));
      end
   endtask

   // Watchdog, sized once the case count is known
   initial begin
      wait (n_cases > 0);
      #(n_cases * CYCLES_PER_CASE * CLK_PERIOD);
      fail_now($sformatf("Timeout: %0d cases did not finish in %0d cycles",
                         n_cases, n_cases * CYCLES_PER_CASE));
   end

   initial begin
      proc_pkg::word_t w;

      clk     = 1'b0;
      rst     = 1'b1;
      pos     = 0;
      n_cases = 0;
      fill_memories();
      $readmemh("tests/proc_cases.txt", cases);
      read_word(w);
      if (w == 16'h0000)
         fail_now("No cases could be read from tests/proc_cases.txt");
      n_cases = int'(w);
      for (int i = 0; i < n_cases; i++)
         run_case(i);
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/proc_cases.txt
// Case count, then per case: program length and words, data count and addr/data pairs,
// store count and expected addr/data pairs in order, expected err
0005
// Arithmetic: LBI, ADD, SUB, XOR, AND, ADDI, stored from base 0x40
000e C125 C213 C040 D94C D951 D956 D95B 41FD 8060 8082 80A4 80C6 80E8 0000
0000
0005 0040 0038 0042 0012 0044 0036 0046 0001 0048 0022
0000
// Dependent chain with negative values
0007 C1F0 4125 D928 DA2D 8060 834D 0000
0000
0002 0000 FFF5 0002 FFEA
0000
// Load, store back, reload the stored word
0008 C110 8940 8148 8962 816A 8988 819E 0000
0002 0010 1234 0012 ABCD
0003 0018 1234 001A ABCD 000E 1234
0000
// Branches and jump, HALTs and stores in the shadows
0011 C100 C201 6204 8040 6104 8042 8044 6904 8026 6A04 8042 0000 2004 0000 8044 8048 0000
0000
0003 0000 0001 0006 0000 0008 0001
0000
// Undefined opcode, then a store, HALT and a store that must not run
0005 C177 F800 8020 0000 8022
0000
0001 0000 0077
0001

// File: verilog.f
verilog/proc_pkg.sv
verilog/pipe_if.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/decode.sv
verilog/hdu.sv
verilog/execute.sv
verilog/memory_wb.sv
verilog/proc.sv
tests/proc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module proc_tb -o proc_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/proc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "TB PASSED"; then
   exit 0
fi
exit 1
